// ==== design/mips_pkg.sv ====
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	localparam int NUM_REGS = 32;

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} func_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		alu_op_e  alu_op;
		logic     use_imm;
		logic     we;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;     // Already extended, shamt for shifts
	} dec_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		logic     we;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

endpackage

// ==== design/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem #(
	parameter int IMEM_WORDS = 64
) (
	input  logic                          clock,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
	input  mips_pkg::word_t               load_word,
	input  logic [$clog2(IMEM_WORDS)-1:0] rd_addr,
	output mips_pkg::word_t               rd_word
);
	import mips_pkg::*;

	word_t mem [IMEM_WORDS];

	// Program load port
	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_word;
		end
	end

	always_ff @(posedge clock) begin
		rd_word <= mem[rd_addr];   // One cycle read latency
	end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter int              IMEM_WORDS = 64,
	parameter mips_pkg::word_t PC_BASE    = 32'h8002_0000
) (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          start,
	output logic [$clog2(IMEM_WORDS)-1:0] rd_addr,
	output logic                          fetch_valid,
	output mips_pkg::word_t               fetch_pc,
	output logic                          running
);
	import mips_pkg::*;

	localparam int AW = $clog2(IMEM_WORDS);

	logic [AW-1:0] cnt;
	logic last;

	assign last = (cnt == AW'(IMEM_WORDS - 1));
	assign rd_addr = cnt;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= running;   // Lines up with rd_word
			if (!running) begin
				if (start) begin
					running <= 1'b1;
					cnt <= '0;
				end
			end else if (last) begin
				running <= 1'b0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		fetch_pc <= PC_BASE + (word_t'(cnt) << 2);
	end

	// A run always begins at word 0
	a_first_pc: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(fetch_valid) |-> fetch_pc == PC_BASE);

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic              clock,
	input  logic              rst_n,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::wb_t     wr,
	output mips_pkg::word_t   rs_val,
	output mips_pkg::word_t   rt_val
);
	import mips_pkg::*;

	word_t regs [NUM_REGS];
	logic wr_en;

	assign wr_en = wr.valid && wr.we;

	// The write strobe already holds the result that execute produced a cycle
	// earlier, so a matching read takes it straight from the strobe
	assign rs_val = (rs == '0) ? '0 : ((wr_en && wr.dest == rs) ? wr.data : regs[rs]);
	assign rt_val = (rt == '0) ? '0 : ((wr_en && wr.dest == rt) ? wr.data : regs[rt]);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// Decode clears we for r0 destinations
	a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
		wr_en |-> wr.dest != '0);

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
	input  logic            clock,
	input  logic            rst_n,
	input  mips_pkg::word_t insn,
	input  logic            insn_valid,
	input  mips_pkg::word_t insn_pc,
	input  mips_pkg::wb_t   wb,
	output mips_pkg::dec_t  dec
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t rs, rt, rd;
	logic [4:0] shamt;
	logic [15:0] imm16;
	logic kept;
	word_t rs_val, rt_val;
	dec_t dec_n;

	assign opcode = insn[31:26];
	assign rs = insn[25:21];
	assign rt = insn[20:16];
	assign rd = insn[15:11];
	assign shamt = insn[10:6];
	assign funct = insn[5:0];
	assign imm16 = insn[15:0];

	reg_file rf_i (
		.clock  (clock),
		.rst_n  (rst_n),
		.rs     (rs),
		.rt     (rt),
		.wr     (wb),
		.rs_val (rs_val),
		.rt_val (rt_val)
	);

	always_comb begin
		kept = 1'b1;
		dec_n = '0;
		dec_n.valid = insn_valid;
		dec_n.pc = insn_pc;
		dec_n.alu_op = ALU_ADD;
		dec_n.use_imm = 1'b1;
		dec_n.rs = rs;
		dec_n.rt = rt;
		dec_n.dest = rt;
		dec_n.rs_val = rs_val;
		dec_n.rt_val = rt_val;
		dec_n.imm = {{16{imm16[15]}}, imm16};
		case (opcode)
			OP_RTYPE: begin
				dec_n.use_imm = 1'b0;
				dec_n.dest = rd;
				dec_n.imm = {27'b0, shamt};   // Shift amount rides in imm
				case (funct)
					F_ADDU: dec_n.alu_op = ALU_ADD;
					F_SUBU: dec_n.alu_op = ALU_SUB;
					F_AND: dec_n.alu_op = ALU_AND;
					F_OR: dec_n.alu_op = ALU_OR;
					F_XOR: dec_n.alu_op = ALU_XOR;
					F_NOR: dec_n.alu_op = ALU_NOR;
					F_SLT: dec_n.alu_op = ALU_SLT;
					F_SLTU: dec_n.alu_op = ALU_SLTU;
					F_SLL: dec_n.alu_op = ALU_SLL;
					F_SRL: dec_n.alu_op = ALU_SRL;
					F_SRA: dec_n.alu_op = ALU_SRA;
					default: kept = 1'b0;
				endcase
			end
			OP_ADDIU: dec_n.alu_op = ALU_ADD;
			OP_SLTI: dec_n.alu_op = ALU_SLT;
			OP_SLTIU: dec_n.alu_op = ALU_SLTU;   // Still sign extended
			OP_ORI: begin
				dec_n.alu_op = ALU_OR;
				dec_n.imm = {16'h0000, imm16};
			end
			OP_XORI: begin
				dec_n.alu_op = ALU_XOR;
				dec_n.imm = {16'h0000, imm16};
			end
			OP_LUI: begin
				dec_n.alu_op = ALU_LUI;
				dec_n.imm = {imm16, 16'h0000};
			end
			default: kept = 1'b0;
		endcase
		dec_n.we = kept && (dec_n.dest != '0);
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec <= dec_n;
		end
	end

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
	input  logic           clock,
	input  logic           rst_n,
	input  mips_pkg::dec_t dec,
	output mips_pkg::wb_t  wb,
	output logic           done
);
	import mips_pkg::*;

	logic fwd_ok;
	word_t op_a, rt_fwd, op_b, result;
	logic [4:0] sh;
	logic wb_valid_d;
	logic retire_we;

	// Previous instruction is not in the register file yet
	assign fwd_ok = wb.valid && wb.we && (wb.dest != '0);
	assign op_a = (fwd_ok && wb.dest == dec.rs) ? wb.data : dec.rs_val;
	assign rt_fwd = (fwd_ok && wb.dest == dec.rt) ? wb.data : dec.rt_val;
	assign op_b = dec.use_imm ? dec.imm : rt_fwd;
	assign sh = dec.imm[4:0];
	assign retire_we = dec.valid && dec.we;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR: result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_NOR: result = ~(op_a | op_b);
			ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: result = {31'b0, op_a < op_b};
			ALU_SLL: result = rt_fwd << sh;
			ALU_SRL: result = rt_fwd >> sh;
			ALU_SRA: result = $unsigned($signed(rt_fwd) >>> sh);
			ALU_LUI: result = op_b;   // Upper half placed by decode
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
			wb.we <= 1'b0;
			wb_valid_d <= 1'b0;
		end else begin
			wb.valid <= dec.valid;
			wb.pc <= dec.pc;
			wb.we <= retire_we;
			wb.dest <= dec.dest;
			wb.data <= retire_we ? result : '0;   // Zero when nothing is written
			wb_valid_d <= wb.valid;
		end
	end

	// Falling edge of the retire strobe
	assign done = wb_valid_d && !wb.valid;

endmodule

// ==== design/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
	parameter int              IMEM_WORDS = 64,
	parameter mips_pkg::word_t PC_BASE    = 32'h8002_0000
) (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
	input  mips_pkg::word_t               load_word,
	input  logic                          start,
	output mips_pkg::wb_t                 wb,
	output logic                          done
);
	import mips_pkg::*;

	logic [$clog2(IMEM_WORDS)-1:0] rd_addr;
	logic fetch_valid;
	word_t rd_word;
	word_t fetch_pc;
	dec_t dec;

	instr_mem #(
		.IMEM_WORDS (IMEM_WORDS)
	) imem_i (
		.clock     (clock),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_word (load_word),
		.rd_addr   (rd_addr),
		.rd_word   (rd_word)
	);

	fetch_unit #(
		.IMEM_WORDS (IMEM_WORDS),
		.PC_BASE    (PC_BASE)
	) fetch_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.rd_addr     (rd_addr),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.running     ()
	);

	decode_unit decode_i (
		.clock      (clock),
		.rst_n      (rst_n),
		.insn       (rd_word),
		.insn_valid (fetch_valid),
		.insn_pc    (fetch_pc),
		.wb         (wb),
		.dec        (dec)
	);

	execute_unit execute_i (
		.clock (clock),
		.rst_n (rst_n),
		.dec   (dec),
		.wb    (wb),
		.done  (done)
	);

endmodule

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic mips_pkg::word_t xorshift32(inout mips_pkg::word_t s);
	s ^= s << 13;
	s ^= s >> 17;
	s ^= s << 5;
	return s;
endfunction

// Registers limited to r0..r7 so that dependencies come often
function automatic mips_pkg::word_t gen_insn(inout mips_pkg::word_t s);
	mips_pkg::word_t r;
	mips_pkg::word_t f;
	logic [5:0] funcs [11];
	logic [5:0] ops [6];
	funcs = '{mips_pkg::F_ADDU, mips_pkg::F_SUBU, mips_pkg::F_AND, mips_pkg::F_OR,
		mips_pkg::F_XOR, mips_pkg::F_NOR, mips_pkg::F_SLT, mips_pkg::F_SLTU,
		mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA};
	ops = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
		mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI};
	r = xorshift32(s);
	f = xorshift32(s);
	if (r[4:0] < 5'd14) begin
		return {6'h00, f[25:6] & 20'h39CFF, funcs[r[8:5] % 11]};
	end else if (r[4:0] < 5'd28) begin
		return {ops[r[8:5] % 6], f[25:0] & 26'h0E7_FFFF};
	end else if (r[4:0] < 5'd30) begin
		return {(r[9] ? 6'h23 : 6'h04), f[25:0]};   // Load and branch opcodes
	end
	return '0;
endfunction

// Runs the program on regs and fills exp with one wb_t per word
function automatic void ref_exec(input mips_pkg::word_t prog[$], input mips_pkg::word_t base,
		inout mips_pkg::word_t regs[32], output mips_pkg::wb_t exp[$]);
	mips_pkg::word_t insn, a, b, res, sx, zx;
	logic [4:0] rs, rt, rd, sh, dest;
	logic ok;
	mips_pkg::wb_t w;
	exp.delete();
	foreach (prog[k]) begin
		insn = prog[k];
		rs = insn[25:21];
		rt = insn[20:16];
		rd = insn[15:11];
		sh = insn[10:6];
		a = (rs == 5'd0) ? '0 : regs[rs];
		b = (rt == 5'd0) ? '0 : regs[rt];
		sx = {{16{insn[15]}}, insn[15:0]};
		zx = {16'h0000, insn[15:0]};
		ok = 1'b1;
		dest = rt;
		res = '0;
		case (insn[31:26])
			mips_pkg::OP_RTYPE: begin
				dest = rd;
				case (insn[5:0])
					mips_pkg::F_ADDU: res = a + b;
					mips_pkg::F_SUBU: res = a - b;
					mips_pkg::F_AND: res = a & b;
					mips_pkg::F_OR: res = a | b;
					mips_pkg::F_XOR: res = a ^ b;
					mips_pkg::F_NOR: res = ~(a | b);
					mips_pkg::F_SLT: res = {31'b0, $signed(a) < $signed(b)};
					mips_pkg::F_SLTU: res = {31'b0, a < b};
					mips_pkg::F_SLL: res = b << sh;
					mips_pkg::F_SRL: res = b >> sh;
					mips_pkg::F_SRA: res = $unsigned($signed(b) >>> sh);
					default: ok = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: res = a + sx;
			mips_pkg::OP_SLTI: res = {31'b0, $signed(a) < $signed(sx)};
			mips_pkg::OP_SLTIU: res = {31'b0, a < sx};
			mips_pkg::OP_ORI: res = a | zx;
			mips_pkg::OP_XORI: res = a ^ zx;
			mips_pkg::OP_LUI: res = {insn[15:0], 16'h0000};
			default: ok = 1'b0;
		endcase
		ok = ok && (dest != 5'd0);
		if (ok) begin
			regs[dest] = res;
		end
		w.valid = 1'b1;
		w.pc = base + 32'(k) * 4;
		w.we = ok;
		w.dest = dest;
		w.data = ok ? res : '0;
		exp.push_back(w);
	end
endfunction

`endif

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
	import mips_pkg::*;

	`include "tb_ref_model.svh"

	localparam int    IMEM_WORDS = 64;
	localparam word_t PC_BASE = 32'h8002_0000;
	localparam int    AW = $clog2(IMEM_WORDS);
	localparam int    RESET_CYCLES = 8;
	localparam int    RUN_CYCLES = IMEM_WORDS + 30;   // Includes the mid-run start poke
	localparam int    LOAD_CYCLES = IMEM_WORDS + 2;
	localparam int    MAX_CYCLES = 3 * RUN_CYCLES + 2 * LOAD_CYCLES + 2 * RESET_CYCLES + 50;

	logic clock;
	logic rst_n;
	logic load_en;
	logic [AW-1:0] load_addr;
	word_t load_word;
	logic start;
	wb_t wb;
	logic done;

	word_t prog[$];
	wb_t exp_q[$];
	word_t model_regs[32];
	word_t rng = 32'hbeeb_91b3;
	int edge_cnt = 0;
	int start_edge = 0;
	logic armed = 1'b0;
	int errors = 0;

	mips_core #(
		.IMEM_WORDS (IMEM_WORDS),
		.PC_BASE    (PC_BASE)
	) dut_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_word (load_word),
		.start     (start),
		.wb        (wb),
		.done      (done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic word_t rtype(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
			input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic fail_value(input string name, input word_t got, input word_t exp);
		errors++;
		$display("Fail %s at %0t: got %h expected %h", name, $time, got, exp);
		$display("Finished with errors");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got.valid !== exp.valid) begin
			fail_value("wb.valid", 32'(got.valid), 32'(exp.valid));
		end else if (exp.valid) begin
			if (got.pc !== exp.pc)
				fail_value("wb.pc", got.pc, exp.pc);
			else if (got.we !== exp.we)
				fail_value("wb.we", 32'(got.we), 32'(exp.we));
			else if (exp.we && got.dest !== exp.dest)
				fail_value("wb.dest", 32'(got.dest), 32'(exp.dest));
			else if (got.data !== exp.data)
				fail_value("wb.data", got.data, exp.data);
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			fail_value("done", 32'(got), 32'(exp));
		end
	endtask

	task automatic build_directed();
		prog = {};
		prog.push_back(itype(OP_LUI, 5'd0, 5'd1, 16'h8000));
		prog.push_back(itype(OP_ORI, 5'd1, 5'd1, 16'h9234));   // Distance 1
		prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'hfffb));   // -5
		prog.push_back(itype(OP_ADDIU, 5'd0, 5'd3, 16'h0007));
		prog.push_back(rtype(5'd2, 5'd3, 5'd4, 5'd0, F_ADDU));
		prog.push_back(rtype(5'd3, 5'd2, 5'd5, 5'd0, F_SUBU));
		prog.push_back(rtype(5'd1, 5'd2, 5'd6, 5'd0, F_AND));
		prog.push_back(rtype(5'd1, 5'd3, 5'd7, 5'd0, F_OR));
		prog.push_back(rtype(5'd2, 5'd3, 5'd8, 5'd0, F_XOR));
		prog.push_back(rtype(5'd2, 5'd3, 5'd9, 5'd0, F_NOR));
		prog.push_back(rtype(5'd2, 5'd3, 5'd10, 5'd0, F_SLT));
		prog.push_back(rtype(5'd2, 5'd3, 5'd11, 5'd0, F_SLTU));
		prog.push_back(rtype(5'd0, 5'd2, 5'd12, 5'd0, F_SLL));
		prog.push_back(rtype(5'd0, 5'd3, 5'd13, 5'd31, F_SLL));
		prog.push_back(rtype(5'd0, 5'd2, 5'd14, 5'd31, F_SRL));
		prog.push_back(rtype(5'd0, 5'd2, 5'd15, 5'd31, F_SRA));
		prog.push_back(rtype(5'd0, 5'd1, 5'd16, 5'd0, F_SRA));
		prog.push_back(itype(OP_SLTI, 5'd2, 5'd17, 16'hfffa));
		prog.push_back(itype(OP_SLTIU, 5'd2, 5'd18, 16'hffff));
		prog.push_back(itype(OP_XORI, 5'd2, 5'd19, 16'h8001));
		prog.push_back(itype(OP_ADDIU, 5'd3, 5'd20, 16'h8000));
		prog.push_back(rtype(5'd3, 5'd3, 5'd0, 5'd0, F_ADDU));   // Targets r0
		prog.push_back(itype(6'h23, 5'd1, 5'd5, 16'h0000));   // LW, not kept
		prog.push_back(rtype(5'd3, 5'd3, 5'd6, 5'd0, 6'h18));   // MULT
		prog.push_back('0);
		prog.push_back(rtype(5'd0, 5'd5, 5'd21, 5'd0, F_ADDU));
		prog.push_back(rtype(5'd0, 5'd0, 5'd22, 5'd0, F_OR));
		prog.push_back(itype(OP_ADDIU, 5'd21, 5'd23, 16'h0001));   // Distance 2
		prog.push_back(rtype(5'd23, 5'd21, 5'd24, 5'd0, F_ADDU));   // Distances 1 and 3
		while (prog.size() < IMEM_WORDS) begin
			prog.push_back('0);
		end
	endtask

	task automatic build_random();
		prog = {};
		for (int i = 0; i < IMEM_WORDS; i++) begin
			prog.push_back(gen_insn(rng));
		end
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(negedge clock);
			load_en = 1'b1;
			load_addr = AW'(i);
			load_word = prog[i];
		end
		@(negedge clock);
		load_en = 1'b0;
	endtask

	task automatic run_program(input logic poke_start);
		@(negedge clock);
		start = 1'b1;
		start_edge <= edge_cnt + 1;
		armed <= 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (poke_start) begin
			repeat (20) @(negedge clock);
			start = 1'b1;   // Must be ignored mid-run
			@(negedge clock);
			start = 1'b0;
		end
		while (!done) @(negedge clock);
		@(negedge clock);
		armed <= 1'b0;
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clock) begin
		int n;
		wb_t exp_w;
		n = edge_cnt - start_edge;
		exp_w = '0;
		if (armed && n >= 3 && n < 3 + IMEM_WORDS) begin
			exp_w = exp_q[n - 3];
		end
		check_wb(wb, exp_w);
		check_done(done, armed && n == 3 + IMEM_WORDS);
	end

	always @(posedge clock) begin
		edge_cnt <= edge_cnt + 1;
		if (edge_cnt >= MAX_CYCLES) begin
			$display("Timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$fatal(1, "Run timed out");
		end
	end

	initial begin
		rst_n = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_word = '0;
		start = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;

		build_directed();
		model_regs = '{default: '0};
		ref_exec(prog, PC_BASE, model_regs, exp_q);
		load_program();
		run_program(1'b1);

		// Registers carry over from the directed run
		build_random();
		ref_exec(prog, PC_BASE, model_regs, exp_q);
		load_program();
		run_program(1'b0);

		@(negedge clock);
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		model_regs = '{default: '0};   // Memory keeps the random program
		ref_exec(prog, PC_BASE, model_regs, exp_q);
		run_program(1'b0);

		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
design/mips_pkg.sv
design/instr_mem.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/mips_core.sv
tb/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
